// ==== Makefile ====
TOP = tb_rw_gen
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module rw_gen_top

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) --Mdir obj_dir -o V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/tb_rw_gen.sv ====
// Directed testbench for rw_gen_top with request and response monitors, checker and watchdog
`timescale 1ns/1ps

module tb_rw_gen;
    import rw_gen_pkg::*;

    localparam int CLK_PERIOD  = 8;
    // Item counts of all jobs and response bursts in the run
    localparam int TOTAL_ITEMS = 6 + 5 + 14 + 6 + 3 + 3;
    localparam int TIMEOUT_NS  = TOTAL_ITEMS * 50 * CLK_PERIOD;

    logic        ap_clk;
    logic        areset_generator;
    logic        config_valid;
    rw_config_t  config_in;
    mem_packet_t engine_in;
    logic        mem_ready;
    mem_packet_t mem_response_in;
    mem_packet_t mem_request_out;
    mem_packet_t engine_response_out;
    logic        done;

    mem_packet_t req_q[$];
    mem_packet_t exp_req_q[$];
    mem_packet_t issued_q[$];
    mem_packet_t resp_q[$];
    int          resp_cycle_q[$];
    int          done_count;
    int          cycle;

    rw_gen_top u_dut (
        .ap_clk              (ap_clk),
        .areset_generator    (areset_generator),
        .config_valid        (config_valid),
        .config_in           (config_in),
        .engine_in           (engine_in),
        .mem_ready           (mem_ready),
        .mem_response_in     (mem_response_in),
        .mem_request_out     (mem_request_out),
        .engine_response_out (engine_response_out),
        .done                (done)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    always @(posedge ap_clk) begin
        cycle <= cycle + 1;
    end

    // --------------------------------------------------
    // Output monitors sampled mid cycle
    // --------------------------------------------------
    always @(negedge ap_clk) begin
        if (mem_request_out.valid) begin
            req_q.push_back(mem_request_out);
        end
        if (engine_response_out.valid) begin
            resp_q.push_back(engine_response_out);
            resp_cycle_q.push_back(cycle);
        end
        if (done) begin
            done_count++;
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] %0t ns: %s got 0x%0h, expected 0x%0h", $time, what, got, expected);
            $display("=== FAIL ===");
            $fatal(1, "Check failed");
        end
    endtask

    task automatic next_cycle();
        @(posedge ap_clk);
        #1;
    endtask

    function automatic rw_config_t make_config(input rw_op_e op, input logic [31:0] base,
                                               input logic [31:0] stride, input int count,
                                               input logic wait_resp, input logic [1:0] dst);
        rw_config_t cfg;
        cfg                  = '0;
        cfg.op               = op;
        cfg.base_addr        = base;
        cfg.stride           = stride;
        cfg.item_count       = 16'(count);
        cfg.wait_responses   = wait_resp;
        cfg.route.dst_module = dst;
        return cfg;
    endfunction

    task automatic start_job(input rw_config_t cfg);
        config_in    = cfg;
        config_valid = 1'b1;
        next_cycle();
        config_valid = 1'b0;
    endtask

    // Each item gets random data and an expected address of base plus index times stride
    task automatic push_items(input rw_config_t cfg);
        mem_packet_t item;
        mem_packet_t exp;
        for (int i = 0; i < int'(cfg.item_count); i++) begin
            item                  = '0;
            item.valid            = 1'b1;
            item.data             = $urandom;
            item.route.src_module = 2'($urandom % 4);
            item.buffer           = BUF_DATA;
            exp                   = item;
            exp.op                = cfg.op;
            exp.address           = cfg.base_addr + 32'(i) * cfg.stride;
            exp.route.dst_module  = cfg.route.dst_module;
            exp_req_q.push_back(exp);
            engine_in = item;
            next_cycle();
        end
        engine_in = '0;
    endtask

    task automatic expect_requests(input int n);
        mem_packet_t got;
        mem_packet_t exp;
        while (req_q.size() < n) begin
            next_cycle();
        end
        for (int k = 0; k < n; k++) begin
            got = req_q.pop_front();
            exp = exp_req_q.pop_front();
            check_value("request address", got.address, exp.address);
            check_value("request data", got.data, exp.data);
            check_value("request op", 32'(got.op), 32'(exp.op));
            check_value("request route", 32'(got.route), 32'(exp.route));
            check_value("request buffer", 32'(got.buffer), 32'(exp.buffer));
            issued_q.push_back(got);
        end
    endtask

    // Exactly one done pulse per job
    task automatic wait_for_done(input int prev);
        while (done_count == prev) begin
            next_cycle();
        end
        repeat (4) next_cycle();
        check_value("done pulses", 32'(done_count), 32'(prev + 1));
        check_value("extra requests", 32'(req_q.size()), 32'd0);
    endtask

    task automatic run_job(input rw_config_t cfg);
        int prev;
        prev = done_count;
        issued_q.delete();
        start_job(cfg);
        push_items(cfg);
        expect_requests(int'(cfg.item_count));
        wait_for_done(prev);
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic check_reset_state();
        areset_generator = 1'b1;
        repeat (10) next_cycle();
        check_value("done in reset", 32'(done), 32'd0);
        check_value("request valid in reset", 32'(mem_request_out.valid), 32'd0);
        check_value("response valid in reset", 32'(engine_response_out.valid), 32'd0);
        areset_generator = 1'b0;
        repeat (3) next_cycle();
        check_value("done after reset", 32'(done), 32'd0);
        check_value("request valid after reset", 32'(mem_request_out.valid), 32'd0);
    endtask

    task automatic run_write_job();
        mem_ready = 1'b1;
        run_job(make_config(OP_WRITE, 32'h1000_0000, 32'd16, 6, 1'b0, 2'd2));
    endtask

    task automatic run_read_job_with_wait();
        rw_config_t  cfg;
        mem_packet_t resp;
        int          prev;
        cfg       = make_config(OP_READ, 32'h2000_0040, 32'd8, 5, 1'b1, 2'd3);
        prev      = done_count;
        mem_ready = 1'b1;
        issued_q.delete();
        resp_q.delete();
        start_job(cfg);
        push_items(cfg);
        expect_requests(5);
        repeat (20) next_cycle();
        check_value("done before responses", 32'(done_count), 32'(prev));
        for (int k = 0; k < 5; k++) begin
            if (k == 4) begin
                mem_response_in = '0;
                repeat (10) next_cycle();
                check_value("done with a read open", 32'(done_count), 32'(prev));
            end
            resp       = issued_q[k];
            resp.data  = $urandom;
            mem_response_in = resp;
            next_cycle();
        end
        mem_response_in = '0;
        wait_for_done(prev);
        check_value("read responses forwarded", 32'(resp_q.size()), 32'd5);
        resp_q.delete();
        resp_cycle_q.delete();
    endtask

    task automatic run_backpressure_job();
        rw_config_t cfg;
        int         prev;
        cfg       = make_config(OP_WRITE, 32'h3000_0000, 32'd4, 14, 1'b0, 2'd0);
        prev      = done_count;
        mem_ready = 1'b0;
        start_job(cfg);
        push_items(cfg);
        repeat (40) next_cycle();
        check_value("requests while held", 32'(req_q.size()), 32'd0);
        check_value("done while held", 32'(done_count), 32'(prev));
        mem_ready = 1'b1;
        expect_requests(14);
        wait_for_done(prev);
    endtask

    // Setup id gets BUF_SETUP two cycles from input to output
    task automatic run_response_retag();
        mem_packet_t pkt;
        mem_packet_t got;
        mem_packet_t exp_q[$];
        int          exp_cycle_q[$];
        resp_q.delete();
        resp_cycle_q.delete();
        for (int k = 0; k < 6; k++) begin
            pkt                  = '0;
            pkt.valid            = 1'b1;
            pkt.op               = (k % 2 == 0) ? OP_READ : OP_WRITE;
            pkt.address          = $urandom;
            pkt.data             = $urandom;
            pkt.route.src_module = 2'(k);
            pkt.route.dst_module = 2'(k % 4);
            pkt.buffer           = (pkt.route.dst_module == 2'd1) ? BUF_DATA : BUF_SETUP;
            mem_response_in      = pkt;
            pkt.buffer           = (pkt.route.dst_module == 2'd1) ? BUF_SETUP : BUF_DATA;
            exp_q.push_back(pkt);
            exp_cycle_q.push_back(cycle + 2);
            next_cycle();
        end
        mem_response_in = '0;
        while (resp_q.size() < 6) begin
            next_cycle();
        end
        for (int k = 0; k < 6; k++) begin
            got = resp_q.pop_front();
            check_value("response address", got.address, exp_q[k].address);
            check_value("response data", got.data, exp_q[k].data);
            check_value("response op", 32'(got.op), 32'(exp_q[k].op));
            check_value("response route", 32'(got.route), 32'(exp_q[k].route));
            check_value("response buffer", 32'(got.buffer), 32'(exp_q[k].buffer));
            check_value("response cycle", 32'(resp_cycle_q.pop_front()), 32'(exp_cycle_q[k]));
        end
    endtask

    task automatic run_back_to_back_jobs();
        mem_ready = 1'b1;
        run_job(make_config(OP_WRITE, 32'h4000_0000, 32'd32, 3, 1'b0, 2'd1));
        run_job(make_config(OP_WRITE, 32'h5000_0100, 32'd12, 3, 1'b0, 2'd2));
    endtask

    initial begin
        void'($urandom(32'h4fd5_7679));
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
        config_valid     = 1'b0;
        config_in        = '0;
        engine_in        = '0;
        mem_ready        = 1'b0;
        mem_response_in  = '0;
        done_count       = 0;
        cycle            = 0;
        check_reset_state();
        run_write_job();
        run_read_job_with_wait();
        run_backpressure_job();
        run_response_retag();
        run_back_to_back_jobs();
        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+src
src/rw_gen_pkg.sv
src/packet_fifo.sv
src/rw_address_kernel.sv
src/memory_response_path.sv
src/rw_gen_control.sv
src/rw_gen_top.sv
bench/tb_rw_gen.sv

// ==== src/memory_response_path.sv ====
// Memory response retag pipeline and outstanding read counter
`timescale 1ns/1ps
`include "rw_gen_defs.svh"

module memory_response_path (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  rw_gen_pkg::mem_packet_t mem_response_in,
    input  rw_gen_pkg::mem_packet_t issued_request,
    output rw_gen_pkg::mem_packet_t engine_response_out,
    output logic                    outstanding_zero
);
    import rw_gen_pkg::*;

    localparam logic [`RW_ID_W-1:0] SETUP_ID = `RW_SETUP_MODULE;

    mem_packet_t            resp_reg;
    mem_packet_t            retagged;
    logic [`RW_COUNT_W-1:0] outstanding;
    logic                   read_issued;
    logic                   resp_seen;

    // --------------------------------------------------
    // Two-cycle retag pipeline
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            resp_reg.valid <= 1'b0;
        end else begin
            resp_reg.valid <= mem_response_in.valid;
        end
        resp_reg.op      <= mem_response_in.op;
        resp_reg.address <= mem_response_in.address;
        resp_reg.data    <= mem_response_in.data;
        resp_reg.route   <= mem_response_in.route;
        resp_reg.buffer  <= mem_response_in.buffer;
    end

    always_comb begin
        retagged        = resp_reg;
        retagged.buffer = (resp_reg.route.dst_module == SETUP_ID) ? BUF_SETUP : BUF_DATA;
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            engine_response_out.valid <= 1'b0;
        end else begin
            engine_response_out.valid <= retagged.valid;
        end
        engine_response_out.op      <= retagged.op;
        engine_response_out.address <= retagged.address;
        engine_response_out.data    <= retagged.data;
        engine_response_out.route   <= retagged.route;
        engine_response_out.buffer  <= retagged.buffer;
    end

    // --------------------------------------------------
    // Outstanding reads
    // --------------------------------------------------
    assign read_issued = issued_request.valid && (issued_request.op == OP_READ);
    assign resp_seen   = mem_response_in.valid;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            outstanding <= '0;
        end else begin
            case ({read_issued, resp_seen})
                2'b10: outstanding <= outstanding + 1'b1;
                2'b01: begin
                    // Stray responses do not wrap the count
                    if (outstanding != '0) begin
                        outstanding <= outstanding - 1'b1;
                    end
                end
                default: outstanding <= outstanding;
            endcase
        end
    end

    // A read leaving this cycle is already counted as outstanding
    assign outstanding_zero = (outstanding == '0) && !read_issued;

endmodule

// ==== src/packet_fifo.sv ====
// Synchronous first-word-fall-through packet FIFO with empty and prog_full flags
`timescale 1ns/1ps
`include "rw_gen_defs.svh"

module packet_fifo (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    push,
    input  rw_gen_pkg::mem_packet_t push_data,
    input  logic                    pop,
    output rw_gen_pkg::mem_packet_t pop_data,
    output logic                    empty,
    output logic                    prog_full
);
    import rw_gen_pkg::*;

    localparam int PTR_W = $clog2(`RW_FIFO_DEPTH);
    localparam logic [PTR_W:0] FULL_LEVEL = `RW_FIFO_DEPTH;
    localparam logic [PTR_W:0] PROG_LEVEL = `RW_PROG_THRESH;

    mem_packet_t      storage [`RW_FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    // A push into a full FIFO is dropped
    assign do_push = push && (count != FULL_LEVEL);
    assign do_pop  = pop && !empty;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            storage[wr_ptr] <= push_data;
        end
    end

    // Head entry is visible before the pop
    assign pop_data  = storage[rd_ptr];
    assign empty     = (count == '0);
    assign prog_full = (count >= PROG_LEVEL);

endmodule

// ==== src/rw_address_kernel.sv ====
// Two-stage address kernel that turns popped engine items into memory requests
`timescale 1ns/1ps
`include "rw_gen_defs.svh"

module rw_address_kernel (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    active,
    input  rw_gen_pkg::rw_config_t  job,
    input  logic                    item_valid,
    input  rw_gen_pkg::mem_packet_t item,
    output rw_gen_pkg::mem_packet_t request,
    output logic                    idle
);
    import rw_gen_pkg::*;

    logic                   s1_valid;
    mem_packet_t            s1_item;
    logic [`RW_COUNT_W-1:0] s1_index;
    logic [`RW_COUNT_W-1:0] item_index;

    // --------------------------------------------------
    // Stage one captures the item and its index
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            s1_valid   <= 1'b0;
            item_index <= '0;
        end else begin
            s1_valid <= item_valid;
            if (!active) begin
                item_index <= '0;
            end else if (item_valid) begin
                item_index <= item_index + 1'b1;
            end
        end
        s1_item  <= item;
        s1_index <= item_index;
    end

    // --------------------------------------------------
    // Stage two builds the request
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            request.valid <= 1'b0;
        end else begin
            request.valid <= s1_valid;
        end
        request.op               <= job.op;
        request.address          <= job.base_addr + (`RW_ADDR_W'(s1_index) * job.stride);
        request.data             <= s1_item.data;
        request.route.src_module <= s1_item.route.src_module;
        request.route.dst_module <= job.route.dst_module;
        request.buffer           <= BUF_DATA;
    end

    assign idle = !s1_valid && !request.valid;

endmodule

// ==== src/rw_gen_control.sv ====
// Job FSM with input pop decision, item counting and done pulse
`timescale 1ns/1ps
`include "rw_gen_defs.svh"

module rw_gen_control (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   config_valid,
    input  rw_gen_pkg::rw_config_t config_in,
    input  logic                   in_empty,
    input  logic                   req_prog_full,
    input  logic                   req_empty,
    input  logic                   kernel_idle,
    input  logic                   outstanding_zero,
    output rw_gen_pkg::rw_config_t job,
    output logic                   active,
    output logic                   in_pop,
    output logic                   done
);
    import rw_gen_pkg::*;

    rw_state_e              state;
    rw_state_e              next_state;
    logic [`RW_COUNT_W-1:0] pop_count;
    logic                   items_left;
    logic                   drained;

    assign items_left = (pop_count < job.item_count);

    // Everything issued and, if asked, every read answered
    assign drained = in_empty && req_empty && kernel_idle &&
                     (outstanding_zero || !job.wait_responses);

    // --------------------------------------------------
    // State register and next state
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RESET: next_state = IDLE;
            IDLE: begin
                if (config_valid) begin
                    next_state = START;
                end
            end
            START: next_state = BUSY;
            BUSY: begin
                if (!items_left) begin
                    next_state = DRAIN;
                end else if (req_prog_full) begin
                    next_state = PAUSE;
                end
            end
            PAUSE: begin
                if (!req_prog_full) begin
                    next_state = BUSY;
                end
            end
            DRAIN: begin
                if (drained) begin
                    next_state = DONE;
                end
            end
            DONE: next_state = IDLE;
            default: next_state = RESET;
        endcase
    end

    // --------------------------------------------------
    // Job latch and pop counter
    // --------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (state == IDLE && config_valid) begin
            job <= config_in;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            pop_count <= '0;
        end else if (state == START) begin
            pop_count <= '0;
        end else if (in_pop) begin
            pop_count <= pop_count + 1'b1;
        end
    end

    assign active = (state == START) || (state == BUSY) || (state == PAUSE) ||
                    (state == DRAIN);
    assign in_pop = (state == BUSY) && !in_empty && items_left && !req_prog_full;
    assign done   = (state == DONE);

endmodule

// ==== src/rw_gen_defs.svh ====
// Width, depth and threshold macros for the read/write request generator
`ifndef RW_GEN_DEFS_SVH
`define RW_GEN_DEFS_SVH

// Datapath widths
`define RW_DATA_W 32
`define RW_ADDR_W 32
`define RW_COUNT_W 16
`define RW_ID_W 2

// FIFO sizing
`define RW_FIFO_DEPTH 16
`define RW_PROG_THRESH 8

// Destination module id that marks a setup response
`define RW_SETUP_MODULE 1

`endif

// ==== src/rw_gen_pkg.sv ====
// Package with opcode, state and buffer enums plus route, config and packet structs
`include "rw_gen_defs.svh"

package rw_gen_pkg;

    // --------------------------------------------------
    // Enumerations
    // --------------------------------------------------
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } rw_op_e;

    typedef enum logic [2:0] {
        RESET = 3'd0,
        IDLE  = 3'd1,
        START = 3'd2,
        BUSY  = 3'd3,
        PAUSE = 3'd4,
        DRAIN = 3'd5,
        DONE  = 3'd6
    } rw_state_e;

    // Class of a response handed back to the engine
    typedef enum logic {
        BUF_SETUP = 1'b0,
        BUF_DATA  = 1'b1
    } buffer_e;

    // --------------------------------------------------
    // Structures
    // --------------------------------------------------
    typedef struct packed {
        logic [`RW_ID_W-1:0] src_module;
        logic [`RW_ID_W-1:0] dst_module;
    } route_t;

    // One job, sampled on the configuration pulse
    typedef struct packed {
        rw_op_e                 op;
        logic [`RW_ADDR_W-1:0]  base_addr;
        logic [`RW_ADDR_W-1:0]  stride;
        logic [`RW_COUNT_W-1:0] item_count;
        logic                   wait_responses;
        route_t                 route;
    } rw_config_t;

    // Shared by engine items, memory requests and memory responses
    typedef struct packed {
        logic                  valid;
        rw_op_e                op;
        logic [`RW_ADDR_W-1:0] address;
        logic [`RW_DATA_W-1:0] data;
        route_t                route;
        buffer_e               buffer;
    } mem_packet_t;

endpackage

// ==== src/rw_gen_top.sv ====
// Top level joining input FIFO, address kernel, request FIFO, response path and control
`timescale 1ns/1ps

module rw_gen_top (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    config_valid,
    input  rw_gen_pkg::rw_config_t  config_in,
    input  rw_gen_pkg::mem_packet_t engine_in,
    input  logic                    mem_ready,
    input  rw_gen_pkg::mem_packet_t mem_response_in,
    output rw_gen_pkg::mem_packet_t mem_request_out,
    output rw_gen_pkg::mem_packet_t engine_response_out,
    output logic                    done
);
    import rw_gen_pkg::*;

    rw_config_t  job;
    logic        active;
    logic        in_pop;
    logic        in_empty;
    mem_packet_t in_item;
    mem_packet_t kernel_request;
    logic        kernel_idle;
    logic        req_pop;
    logic        req_empty;
    logic        req_prog_full;
    mem_packet_t req_head;
    logic        outstanding_zero;

    // --------------------------------------------------
    // Engine items in, requests out
    // --------------------------------------------------
    packet_fifo u_input_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (engine_in.valid),
        .push_data        (engine_in),
        .pop              (in_pop),
        .pop_data         (in_item),
        .empty            (in_empty),
        .prog_full        ()
    );

    rw_address_kernel u_kernel (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .active           (active),
        .job              (job),
        .item_valid       (in_pop),
        .item             (in_item),
        .request          (kernel_request),
        .idle             (kernel_idle)
    );

    assign req_pop = mem_ready && !req_empty;

    packet_fifo u_request_fifo (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (kernel_request.valid),
        .push_data        (kernel_request),
        .pop              (req_pop),
        .pop_data         (req_head),
        .empty            (req_empty),
        .prog_full        (req_prog_full)
    );

    // Request output is valid one cycle after the pop
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mem_request_out.valid <= 1'b0;
        end else begin
            mem_request_out.valid <= req_pop;
        end
        mem_request_out.op      <= req_head.op;
        mem_request_out.address <= req_head.address;
        mem_request_out.data    <= req_head.data;
        mem_request_out.route   <= req_head.route;
        mem_request_out.buffer  <= req_head.buffer;
    end

    // --------------------------------------------------
    // Responses and job control
    // --------------------------------------------------
    memory_response_path u_response_path (
        .ap_clk              (ap_clk),
        .areset_generator    (areset_generator),
        .mem_response_in     (mem_response_in),
        .issued_request      (mem_request_out),
        .engine_response_out (engine_response_out),
        .outstanding_zero    (outstanding_zero)
    );

    rw_gen_control u_control (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .config_valid     (config_valid),
        .config_in        (config_in),
        .in_empty         (in_empty),
        .req_prog_full    (req_prog_full),
        .req_empty        (req_empty),
        .kernel_idle      (kernel_idle),
        .outstanding_zero (outstanding_zero),
        .job              (job),
        .active           (active),
        .in_pop           (in_pop),
        .done             (done)
    );

endmodule
